// File: compile.f
+incdir+verif
hw/sv_board_pkg.sv
hw/sv_dpram.sv
hw/sv_cart_loader.sv
hw/sv_palette_blend.sv
hw/sv_board_top.sv
verif/sv_board_chk.sv
verif/sv_board_tb.sv

// File: hw/sv_board_pkg.sv
package sv_board_pkg;

	localparam int byte_w = 8;       // cartridge data width
	localparam int index_w = 8;      // download index width
	localparam int index_cmp_w = 6;  // only low bits of the index count
	localparam int chan_w = 8;       // per colour channel

	typedef logic [1:0] pix_t;       // palette index from the core

	typedef struct packed {
		logic [chan_w-1:0] r;
		logic [chan_w-1:0] g;
		logic [chan_w-1:0] b;
	} rgb_t;

	// greenish lcd look
	localparam rgb_t default_palette [4] = '{
		rgb_t'(24'h87BA6B),
		rgb_t'(24'h6BA378),
		rgb_t'(24'h386B82),
		rgb_t'(24'h384052)
	};

	localparam rgb_t custom_palette [4] = '{
		rgb_t'(24'hF7BEF7),
		rgb_t'(24'hE78686),
		rgb_t'(24'h7733E7),
		rgb_t'(24'h2C2C96)
	};

	// .bin and .sv cartridge images
	localparam logic [index_cmp_w-1:0] cart_index_bin = 6'd0;
	localparam logic [index_cmp_w-1:0] cart_index_sv = 6'd1;

endpackage

// File: hw/sv_board_top.sv
`timescale 1ns/1ps

module sv_board_top #(
	parameter int rom_aw = 19,
	parameter int fb_aw = 15
) (
	input  logic                             clk_sys,
	input  logic                             rst,

	input  logic                             dl_active,
	input  logic [sv_board_pkg::index_w-1:0] dl_index,
	input  logic                             dl_wr,
	input  logic [rom_aw-1:0]                dl_addr,
	input  logic [sv_board_pkg::byte_w-1:0]  dl_data,

	input  logic                             reset_req,
	input  logic                             button_reset,
	output logic                             core_reset,

	input  logic                             rom_read,
	input  logic [rom_aw-1:0]                rom_addr,
	output logic [sv_board_pkg::byte_w-1:0]  rom_data,
	output logic                             rom_ready,
	output logic                             large_rom,

	input  logic                             pix_ce,
	input  sv_board_pkg::pix_t               pixel,
	input  logic                             hblank,
	input  logic                             vblank,
	input  logic                             hsync,
	input  logic                             vsync,
	input  logic                             custom_pal,
	input  logic                             blend_en,

	output logic [sv_board_pkg::chan_w-1:0]  red,
	output logic [sv_board_pkg::chan_w-1:0]  green,
	output logic [sv_board_pkg::chan_w-1:0]  blue,
	output logic                             hs_out,
	output logic                             vs_out
);

	import sv_board_pkg::*;

	logic              mem_wr_en;
	logic [rom_aw-1:0] mem_wr_addr;
	logic [byte_w-1:0] mem_wr_data;
	logic [rom_aw-1:0] mem_rd_addr;
	logic [byte_w-1:0] mem_rd_data;

	logic              fb_wr_en;
	logic [fb_aw-1:0]  fb_addr;
	pix_t              fb_wr_pixel;
	pix_t              fb_rd_pixel;

	sv_cart_loader #(
		.rom_aw(rom_aw)
	) i_loader (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.reset_req   (reset_req),
		.button_reset(button_reset),
		.rom_read    (rom_read),
		.rom_addr    (rom_addr),
		.rom_data    (rom_data),
		.rom_ready   (rom_ready),
		.large_rom   (large_rom),
		.core_reset  (core_reset),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.mem_wr_data (mem_wr_data),
		.mem_rd_addr (mem_rd_addr),
		.mem_rd_data (mem_rd_data)
	);

	// stands in for the sdram
	sv_dpram #(
		.word_t(logic [byte_w-1:0]),
		.addr_w(rom_aw)
	) cart_mem (
		.clk_sys(clk_sys),
		.wr_en  (mem_wr_en),
		.wr_addr(mem_wr_addr),
		.wr_data(mem_wr_data),
		.rd_addr(mem_rd_addr),
		.rd_data(mem_rd_data)
	);

	sv_palette_blend #(
		.fb_aw(fb_aw)
	) i_video (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.pix_ce     (pix_ce),
		.pixel      (pixel),
		.hblank     (hblank),
		.vblank     (vblank),
		.hsync      (hsync),
		.vsync      (vsync),
		.custom_pal (custom_pal),
		.blend_en   (blend_en),
		.fb_wr_en   (fb_wr_en),
		.fb_addr    (fb_addr),
		.fb_wr_pixel(fb_wr_pixel),
		.fb_rd_pixel(fb_rd_pixel),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.hs_out     (hs_out),
		.vs_out     (vs_out)
	);

	// previous frame for the blend
	sv_dpram #(
		.word_t(pix_t),
		.addr_w(fb_aw)
	) frame_buf (
		.clk_sys(clk_sys),
		.wr_en  (fb_wr_en),
		.wr_addr(fb_addr),
		.wr_data(fb_wr_pixel),
		.rd_addr(fb_addr),
		.rd_data(fb_rd_pixel)
	);

endmodule

// File: hw/sv_cart_loader.sv
`timescale 1ns/1ps

module sv_cart_loader #(
	parameter int rom_aw = 19
) (
	input  logic                             clk_sys,
	input  logic                             rst,

	input  logic                             dl_active,
	input  logic [sv_board_pkg::index_w-1:0] dl_index,
	input  logic                             dl_wr,
	input  logic [rom_aw-1:0]                dl_addr,
	input  logic [sv_board_pkg::byte_w-1:0]  dl_data,

	input  logic                             reset_req,
	input  logic                             button_reset,

	input  logic                             rom_read,
	input  logic [rom_aw-1:0]                rom_addr,
	output logic [sv_board_pkg::byte_w-1:0]  rom_data,
	output logic                             rom_ready,
	output logic                             large_rom,
	output logic                             core_reset,

	output logic                             mem_wr_en,
	output logic [rom_aw-1:0]                mem_wr_addr,
	output logic [sv_board_pkg::byte_w-1:0]  mem_wr_data,
	output logic [rom_aw-1:0]                mem_rd_addr,
	input  logic [sv_board_pkg::byte_w-1:0]  mem_rd_data
);

	import sv_board_pkg::*;

	logic [index_cmp_w-1:0] idx;
	logic                   cart_idx;
	logic                   rom_download;
	logic [rom_aw-1:0]      rom_mask;

	assign idx = dl_index[index_cmp_w-1:0];
	assign cart_idx = (idx == cart_index_bin) || (idx == cart_index_sv);
	assign rom_download = dl_active && cart_idx;

	// download bytes go straight into the cartridge ram
	assign mem_wr_en = rom_download && dl_wr;
	assign mem_wr_addr = dl_addr;
	assign mem_wr_data = dl_data;

	// last written address, i.e. size - 1
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_mask <= '1;
		end else if (mem_wr_en) begin
			rom_mask <= dl_addr;
		end
	end

	assign large_rom = |rom_mask[rom_aw-1 -: 2];  // above 1/4 of the space

	// mirror small carts over the whole address range
	assign mem_rd_addr = rom_addr & rom_mask;

	// ram read is registered so data lines up with ready
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			rom_ready <= 1'b0;
		end else begin
			rom_ready <= rom_read && !rom_download;  // no fetches while loading
		end
	end

	assign rom_data = mem_rd_data;

	// hold the core while a cart is loading
	assign core_reset = rst | reset_req | button_reset | rom_download;

endmodule

// File: hw/sv_dpram.sv
`timescale 1ns/1ps

module sv_dpram #(
	parameter type word_t = logic [7:0],
	parameter int addr_w = 8
) (
	input  logic              clk_sys,
	input  logic              wr_en,
	input  logic [addr_w-1:0] wr_addr,
	input  word_t             wr_data,
	input  logic [addr_w-1:0] rd_addr,
	output word_t             rd_data
);

	localparam int depth = 2 ** addr_w;

	word_t mem [depth];

	// write port
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// registered read, old word on a same-address collision
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: hw/sv_palette_blend.sv
`timescale 1ns/1ps

module sv_palette_blend #(
	parameter int fb_aw = 15
) (
	input  logic                            clk_sys,
	input  logic                            rst,

	input  logic                            pix_ce,
	input  sv_board_pkg::pix_t              pixel,
	input  logic                            hblank,
	input  logic                            vblank,
	input  logic                            hsync,
	input  logic                            vsync,

	input  logic                            custom_pal,
	input  logic                            blend_en,

	output logic                            fb_wr_en,
	output logic [fb_aw-1:0]                fb_addr,
	output sv_board_pkg::pix_t              fb_wr_pixel,
	input  sv_board_pkg::pix_t              fb_rd_pixel,

	output logic [sv_board_pkg::chan_w-1:0] red,
	output logic [sv_board_pkg::chan_w-1:0] green,
	output logic [sv_board_pkg::chan_w-1:0] blue,
	output logic                            hs_out,
	output logic                            vs_out
);

	import sv_board_pkg::*;

	logic             visible;
	logic [fb_aw-1:0] pos;
	rgb_t             cur_rgb;
	rgb_t             prev_rgb;
	rgb_t             mix_rgb;

	function automatic logic [chan_w-1:0] avg(
		input logic [chan_w-1:0] a,
		input logic [chan_w-1:0] b
	);
		logic [chan_w:0] sum;
		sum = {1'b0, a} + b;
		return sum[chan_w:1];
	endfunction

	assign visible = ~hblank & ~vblank;

	// position of the current visible pixel in the frame
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pos <= '0;
		end else if (pix_ce) begin
			if (vsync) begin
				pos <= '0;  // new frame
			end else if (visible) begin
				pos <= pos + 1'b1;
			end
		end
	end

	// read and write share the counter; the read still sees last frame
	assign fb_addr = pos;
	assign fb_wr_en = pix_ce & visible;
	assign fb_wr_pixel = pixel;

	always_comb begin
		cur_rgb = custom_pal ? custom_palette[pixel] : default_palette[pixel];
		prev_rgb = custom_pal ? custom_palette[fb_rd_pixel] : default_palette[fb_rd_pixel];
		mix_rgb = cur_rgb;
		if (blend_en) begin
			mix_rgb.r = avg(cur_rgb.r, prev_rgb.r);  // flicker blend
			mix_rgb.g = avg(cur_rgb.g, prev_rgb.g);
			mix_rgb.b = avg(cur_rgb.b, prev_rgb.b);
		end
	end

	// outputs move only on the pixel enable
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			red <= '0;
			green <= '0;
			blue <= '0;
			hs_out <= 1'b0;
			vs_out <= 1'b0;
		end else if (pix_ce) begin
			red <= visible ? mix_rgb.r : '0;  // black in blanking
			green <= visible ? mix_rgb.g : '0;
			blue <= visible ? mix_rgb.b : '0;
			hs_out <= hsync;
			vs_out <= vsync;
		end
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the board testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module sv_board_tb -Mdir "$obj" -o sim_board
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$obj/sim_board" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Some tests failed" "$log"; then
	echo "simulation reported a failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "All tests passed" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi

echo "simulation passed"
exit 0

// File: verif/sv_board_chk.sv
`timescale 1ns/1ps

module sv_board_chk (
	input logic                             clk_sys,
	input logic                             rst,
	input logic                             pix_ce,
	input logic                             rom_read,
	input logic                             rom_ready,
	input logic                             dl_active,
	input logic [sv_board_pkg::index_w-1:0] dl_index,
	input logic                             mem_wr_en
);

	import sv_board_pkg::*;

	logic dl_qual;

	assign dl_qual = dl_active && ((dl_index[index_cmp_w-1:0] == cart_index_bin)
		|| (dl_index[index_cmp_w-1:0] == cart_index_sv));

	a_pix_ce_gap: assert property (@(posedge clk_sys) disable iff (rst) pix_ce |=> !pix_ce)
		else $error("pix_ce high on two consecutive cycles");

	a_rom_ready: assert property (@(posedge clk_sys) disable iff (rst)
		rom_read && !dl_qual |=> rom_ready)
		else $error("rom_read without rom_ready one cycle later");

	a_wr_qual: assert property (@(posedge clk_sys) disable iff (rst) mem_wr_en |-> dl_qual)
		else $error("cartridge ram written outside a cartridge download");

endmodule

bind sv_cart_loader sv_board_chk i_chk (
	.clk_sys  (clk_sys),
	.rst      (rst),
	.pix_ce   (1'b0),
	.rom_read (rom_read),
	.rom_ready(rom_ready),
	.dl_active(dl_active),
	.dl_index (dl_index),
	.mem_wr_en(mem_wr_en)
);

bind sv_palette_blend sv_board_chk i_chk (
	.clk_sys  (clk_sys),
	.rst      (rst),
	.pix_ce   (pix_ce),
	.rom_read (1'b0),
	.rom_ready(1'b0),
	.dl_active(1'b0),
	.dl_index (8'h00),
	.mem_wr_en(1'b0)
);

// File: verif/sv_board_tests.svh
task automatic check_rgb(input rgb_t exp);
	check("red", red, exp.r);
	check("green", green, exp.g);
	check("blue", blue, exp.b);
endtask

// one pixel enable, always after an idle cycle
task automatic pix_strobe(input pix_t p, input logic hb, input logic vb,
	input logic hs, input logic vs);
	next_cycle;
	pix_ce = 1'b1;
	pixel = p;
	hblank = hb;
	vblank = vb;
	hsync = hs;
	vsync = vs;
	next_cycle;
	pix_ce = 1'b0;
endtask

task automatic download(input logic [index_w-1:0] index, input int n);
	logic              qual;
	logic [byte_w-1:0] data;
	logic [rom_aw-1:0] addr;
	int                i;
	qual = (index[5:0] == 6'd0) || (index[5:0] == 6'd1);
	dl_active = 1'b1;
	dl_index = index;
	for (i = 0; i < n; i++) begin
		next_cycle;
		if (!qual) check("core_reset", core_reset, 0);
		data = 8'($urandom);
		addr = rom_aw'(i);  // foreign bytes aim at the cart area too
		if (qual) rom_model[addr] = data;
		dl_wr = 1'b1;
		dl_addr = addr;
		dl_data = data;
	end
	next_cycle;
	dl_wr = 1'b0;
	next_cycle;
	dl_active = 1'b0;
	dl_index = '0;
	next_cycle;
	check("core_reset", core_reset, 0);
endtask

// back to back fetches, one ready per strobe
task automatic read_burst(input logic [rom_aw-1:0] mask);
	int i;
	for (i = 0; i < n_reads; i++) begin
		rom_read = 1'b1;
		rom_addr = read_addr[i];
		next_cycle;
		check("rom_ready", rom_ready, 1);
		check("rom_data", rom_data, rom_model[read_addr[i] & mask]);
	end
	rom_read = 1'b0;
	next_cycle;
	check("rom_ready", rom_ready, 0);
endtask

task automatic test_reset_state;
	check_rgb(rgb_t'(0));
	check("hs_out", hs_out, 0);
	check("vs_out", vs_out, 0);
	check("rom_ready", rom_ready, 0);
	check("large_rom", large_rom, 1);
	check("core_reset", core_reset, 0);
	reset_req = 1'b1;
	next_cycle;
	check("core_reset", core_reset, 1);
	reset_req = 1'b0;
	button_reset = 1'b1;
	next_cycle;
	check("core_reset", core_reset, 1);
	button_reset = 1'b0;
	dl_active = 1'b1;
	dl_index = 8'h00;
	next_cycle;
	check("core_reset", core_reset, 1);
	dl_index = 8'h41;  // only the low six bits count
	rom_read = 1'b1;
	next_cycle;
	check("core_reset", core_reset, 1);
	check("rom_ready", rom_ready, 0);
	rom_read = 1'b0;
	dl_index = 8'h05;
	next_cycle;
	check("core_reset", core_reset, 0);
	dl_active = 1'b0;
	dl_index = '0;
	next_cycle;
	check("core_reset", core_reset, 0);
	check("large_rom", large_rom, 1);
endtask

task automatic test_download_reads;
	int i;
	download(8'h01, n_bytes);
	check("large_rom", large_rom, 0);
	for (i = 0; i < n_reads; i++) read_addr[i] = rom_aw'($urandom);
	read_burst(rom_aw'(n_bytes - 1));
endtask

task automatic test_index_filter;
	download(8'h05, n_bytes / 4);
	check("large_rom", large_rom, 0);
	read_burst(rom_aw'(n_bytes - 1));  // same answers as before
endtask

task automatic test_palette;
	rgb_t col;
	int   cp;
	int   p;
	blend_en = 1'b0;
	for (cp = 0; cp < 2; cp++) begin
		custom_pal = cp[0];
		for (p = 0; p < 4; p++) begin
			pix_strobe(pix_t'(p), 1'b0, 1'b0, 1'b0, 1'b0);
			col = pal_color(cp[0], pix_t'(p));
			check_rgb(col);
			check("hs_out", hs_out, 0);
			next_cycle;
			check_rgb(col);  // holds between enables
			pix_strobe(pix_t'(p), 1'b1, 1'b0, 1'b1, 1'b0);
			check_rgb(rgb_t'(0));
			check("hs_out", hs_out, 1);
			pix_strobe(pix_t'(p), 1'b0, 1'b1, 1'b0, 1'b0);
			check_rgb(rgb_t'(0));
		end
	end
endtask

task automatic test_flicker_blend;
	rgb_t cur;
	rgb_t prev;
	rgb_t exp;
	pix_t p;
	int   f;
	int   i;
	blend_en = 1'b1;
	custom_pal = 1'b0;
	for (f = 0; f < n_frames; f++) begin
		pix_strobe(pix_t'(0), 1'b1, 1'b1, 1'b0, 1'b1);
		check("vs_out", vs_out, 1);
		check_rgb(rgb_t'(0));
		for (i = 0; i < frame_px; i++) begin
			if (i != 0 && i % line_px == 0) begin
				pix_strobe(pix_t'(0), 1'b1, 1'b0, 1'b1, 1'b0);  // line gap
				check("hs_out", hs_out, 1);
				check_rgb(rgb_t'(0));
			end
			p = pix_t'($urandom);
			pix_strobe(p, 1'b0, 1'b0, 1'b0, 1'b0);
			check("vs_out", vs_out, 0);
			if (f > 0) begin
				cur = pal_color(custom_pal, p);
				prev = pal_color(custom_pal, frame_model[i]);
				exp.r = half_sum(cur.r, prev.r);
				exp.g = half_sum(cur.g, prev.g);
				exp.b = half_sum(cur.b, prev.b);
				check_rgb(exp);
			end
			frame_model[i] = p;
		end
	end
	blend_en = 1'b0;
endtask

// File: verif/sv_board_tb.sv
`timescale 1ns/1ps

module sv_board_tb;

	import sv_board_pkg::*;

	localparam int clk_period = 40;
	localparam int drive_dly = 2;
	localparam int rst_cycles = 16;
	localparam int rom_aw = 16;
	localparam int fb_aw = 15;
	localparam int n_bytes = 1024;  // power of two
	localparam int n_reads = 64;
	localparam int line_px = 8;
	localparam int frame_px = 32;
	localparam int n_frames = 2;
	localparam logic [31:0] seed = 32'hd2385bcd;
	localparam int wd_cycles = rst_cycles + 2 * n_bytes + 4 * n_reads + 200
		+ 4 * n_frames * (frame_px + frame_px / line_px + 1);

	logic                 clk_sys;
	logic                 rst;
	logic                 dl_active;
	logic [index_w-1:0]   dl_index;
	logic                 dl_wr;
	logic [rom_aw-1:0]    dl_addr;
	logic [byte_w-1:0]    dl_data;
	logic                 reset_req;
	logic                 button_reset;
	logic                 core_reset;
	logic                 rom_read;
	logic [rom_aw-1:0]    rom_addr;
	logic [byte_w-1:0]    rom_data;
	logic                 rom_ready;
	logic                 large_rom;
	logic                 pix_ce;
	pix_t                 pixel;
	logic                 hblank;
	logic                 vblank;
	logic                 hsync;
	logic                 vsync;
	logic                 custom_pal;
	logic                 blend_en;
	logic [chan_w-1:0]    red;
	logic [chan_w-1:0]    green;
	logic [chan_w-1:0]    blue;
	logic                 hs_out;
	logic                 vs_out;

	logic [byte_w-1:0]    rom_model [2**rom_aw];  // bytes of the last cart
	pix_t                 frame_model [frame_px];  // previous frame
	logic [rom_aw-1:0]    read_addr [n_reads];

	sv_board_top #(
		.rom_aw(rom_aw),
		.fb_aw (fb_aw)
	) i_dut (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.reset_req   (reset_req),
		.button_reset(button_reset),
		.core_reset  (core_reset),
		.rom_read    (rom_read),
		.rom_addr    (rom_addr),
		.rom_data    (rom_data),
		.rom_ready   (rom_ready),
		.large_rom   (large_rom),
		.pix_ce      (pix_ce),
		.pixel       (pixel),
		.hblank      (hblank),
		.vblank      (vblank),
		.hsync       (hsync),
		.vsync       (vsync),
		.custom_pal  (custom_pal),
		.blend_en    (blend_en),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.hs_out      (hs_out),
		.vs_out      (vs_out)
	);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	task automatic next_cycle;
		@(posedge clk_sys);
		#(drive_dly);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	function automatic rgb_t pal_color(input logic cp, input pix_t p);
		return cp ? custom_palette[p] : default_palette[p];
	endfunction

	// per channel (a + b) / 2, rounding down
	function automatic logic [chan_w-1:0] half_sum(
		input logic [chan_w-1:0] a,
		input logic [chan_w-1:0] b
	);
		logic [chan_w:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		return sum[chan_w:1];
	endfunction

	`include "sv_board_tests.svh"

	initial begin
		#(2 * wd_cycles * clk_period);
		$display("Some tests failed");
		$fatal(1, "watchdog expired before the tests finished");
	end

	initial begin
		void'($urandom(seed));
		clk_sys = 1'b0;
		rst = 1'b1;
		dl_active = 1'b0;
		dl_index = '0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		reset_req = 1'b0;
		button_reset = 1'b0;
		rom_read = 1'b0;
		rom_addr = '0;
		pix_ce = 1'b0;
		pixel = '0;
		hblank = 1'b0;
		vblank = 1'b0;
		hsync = 1'b0;
		vsync = 1'b0;
		custom_pal = 1'b0;
		blend_en = 1'b0;
		repeat (rst_cycles) @(posedge clk_sys);
		#(drive_dly);
		check("core_reset", core_reset, 1);  // held during rst
		rst = 1'b0;
		next_cycle;
		test_reset_state;
		test_download_reads;
		test_index_filter;
		test_palette;
		test_flicker_blend;
		$display("All tests passed");
		$finish;
	end

endmodule
